// File: Bender.yml
package:
  name: fmul

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fmul_pkg.sv
      - rtl/fmul_ctrl.sv
      - rtl/fmul_unpack.sv
      - rtl/fmul_mant_mult.sv
      - rtl/fmul_normalize.sv
      - rtl/fmul_round_pack.sv
      - rtl/fmul_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/fmul_clkgen.sv
      - bench/fmul_chk.sv
      - bench/fmul_tb.sv

// File: all.f
+incdir+rtl
rtl/fmul_pkg.sv
rtl/fmul_ctrl.sv
rtl/fmul_unpack.sv
rtl/fmul_mant_mult.sv
rtl/fmul_normalize.sv
rtl/fmul_round_pack.sv
rtl/fmul_top.sv
bench/fmul_clkgen.sv
bench/fmul_chk.sv
bench/fmul_tb.sv

// File: bench/fmul_chk.sv
module fmul_chk (
  input logic clk,
  input logic rst,
  input logic done,
  input logic busy
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count; // failed assertions so far

  // done is a single-cycle pulse
  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
      $error("done stayed high for two cycles");
      fail_count++;
    end

  done_in_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
    else
    begin
      $error("done pulsed while busy was low");
      fail_count++;
    end

  // reset leaves the outputs quiet
  reset_clears: assert property (@(posedge clk) rst |=> (!done && !busy))
    else
    begin
      $error("done or busy high in the cycle after reset");
      fail_count++;
    end

endmodule

// File: bench/fmul_clkgen.sv
module fmul_clkgen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 10; // 20 ns clock

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // held over two rising edges
  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: bench/fmul_tb.sv
`include "fmul_params.svh"

module fmul_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int op_count   = 70;   // upper bound on issued operations
  localparam int margin_ns  = 2000;
  localparam int done_limit = 8;    // edges allowed before done

  logic               clk;
  logic               por_rst;
  logic               mid_rst;      // reset during an operation
  logic               rst;
  logic               in_valid;
  logic [`FMUL_W-1:0] a_in;
  logic [`FMUL_W-1:0] b_in;
  logic [`FMUL_W-1:0] z;
  fmul_pkg::status_t  status;
  logic               done;
  logic               busy;
  int                 mismatches;
  int                 others;

  assign rst = por_rst | mid_rst;

  fmul_clkgen clkgen_i (.clk, .rst(por_rst));

  fmul_top dut_i (.clk, .rst, .in_valid, .a(a_in), .b(b_in), .z, .status, .done, .busy);

  bind fmul_top fmul_chk chk_i (.clk, .rst, .done, .busy);

  // any non-normal class takes the short path
  function automatic logic is_special(input logic [31:0] x, input logic [31:0] y);
    return (x[30:23] == 8'h00) || (x[30:23] == 8'hff) || (y[30:23] == 8'h00) ||
           (y[30:23] == 8'hff);
  endfunction

  // reference result as {invalid, overflow, underflow, z}
  function automatic logic [34:0] model_mul(input logic [31:0] x, input logic [31:0] y);
    logic [7:0]  ex;
    logic [7:0]  ey;
    logic        s;
    logic        x_nan;
    logic        y_nan;
    logic        x_inf;
    logic        y_inf;
    logic        x_zero;
    logic        y_zero;
    logic [47:0] p;
    logic [47:0] rem;
    logic [47:0] half;
    logic [24:0] m;
    int          sh;
    int          e;
    ex     = x[30:23];
    ey     = y[30:23];
    s      = x[31] ^ y[31];
    x_zero = ex == 8'h00;                 // subnormals count as zero
    y_zero = ey == 8'h00;
    x_inf  = (ex == 8'hff) && (x[22:0] == 0);
    y_inf  = (ey == 8'hff) && (y[22:0] == 0);
    x_nan  = (ex == 8'hff) && (x[22:0] != 0);
    y_nan  = (ey == 8'hff) && (y[22:0] != 0);
    if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero))
      return {3'b100, 32'h7fc0_0000};
    if (x_inf || y_inf)
      return {3'b000, s, 8'hff, 23'd0};
    if (x_zero || y_zero)
      return {3'b000, s, 31'd0};
    p    = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
    e    = int'(ex) + int'(ey) - 127;     // biased result exponent
    sh   = p[47] ? 24 : 23;
    e    = p[47] ? e + 1 : e;
    m    = 25'(p >> sh);
    rem  = p & ((48'd1 << sh) - 48'd1);   // discarded bits
    half = 48'd1 << (sh - 1);
    if ((rem > half) || ((rem == half) && m[0]))
      m = m + 25'd1;
    if (m[24])
    begin
      m = m >> 1;                         // carry out of rounding
      e = e + 1;
    end
    if (e > 254)
      return {3'b010, s, 8'hff, 23'd0};
    if (e < 1)
      return {3'b001, s, 31'd0};
    return {3'b000, s, e[7:0], m[22:0]};
  endfunction

  function automatic logic [31:0] rand_normal();
    logic [7:0] e;
    e = 8'(100 + $urandom_range(54));    // keeps the product in range
    return {1'($urandom), e, 23'($urandom)};
  endfunction

  task automatic issue(input logic [31:0] x, input logic [31:0] y);
    @(posedge clk);
    in_valid <= 1'b1;
    a_in     <= x;
    b_in     <= y;
    @(posedge clk);                       // accept edge
    in_valid <= 1'b0;
  endtask

  // edges counted from the accept edge and sampled at the falling edge
  task automatic wait_done(input string name, output int edges, output logic seen);
    edges = 1;
    @(negedge clk);
    while (!done && (edges < done_limit))
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    seen = done;
    assert (seen)
    else
    begin
      others++;
      $display("%s: no done pulse within %0d clock edges", name, done_limit);
    end
  endtask

  task automatic check_op(input string name, input logic [31:0] x, input logic [31:0] y);
    logic [34:0] exp_r;
    logic [2:0]  flags;
    int          edges;
    int          exp_edges;
    logic        seen;
    exp_r     = model_mul(x, y);
    exp_edges = is_special(x, y) ? 2 : 4;
    issue(x, y);
    wait_done(name, edges, seen);
    flags = status;
    if (seen)
    begin
      assert (z === exp_r[31:0])
      else
      begin
        mismatches++;
        $display("MISMATCH %s z expected %h actual %h", name, exp_r[31:0], z);
      end
      assert (flags === exp_r[34:32])
      else
      begin
        mismatches++;
        $display("MISMATCH %s status expected %b actual %b", name, exp_r[34:32], flags);
      end
      assert (edges == exp_edges)
      else
      begin
        mismatches++;
        $display("MISMATCH %s latency expected %0d actual %0d", name, exp_edges, edges);
      end
    end
  endtask

  task automatic exact_products();
    logic [31:0] x;
    x = rand_normal();
    check_op("exact 1.5*2.0", 32'h3fc0_0000, 32'h4000_0000);
    check_op("exact -3.0*0.25", 32'hc040_0000, 32'h3e80_0000);
    check_op("exact 1.0*x", 32'h3f80_0000, x);
    check_op("exact x*1.0", x, 32'h3f80_0000);
  endtask

  task automatic rounding_cases();
    check_op("tie odd lsb", 32'h3f80_0001, 32'h3fc0_0000);  // rounds up to even
    check_op("tie even lsb", 32'h3f80_0002, 32'h3fa0_0000); // stays put
    for (int i = 0; i < 40; i++)
      check_op($sformatf("round rand %0d", i), rand_normal(), rand_normal());
  endtask

  task automatic special_operands();
    check_op("nan times one", 32'h7fc0_0001, 32'h3f80_0000);
    check_op("one times neg snan", 32'h3f80_0000, 32'hff80_0001);
    check_op("snan times neg inf", 32'h7f80_0001, 32'hff80_0000);
    check_op("inf times zero", 32'h7f80_0000, 32'h0000_0000);
    check_op("neg zero times inf", 32'h8000_0000, 32'h7f80_0000);
    check_op("inf times neg two", 32'h7f80_0000, 32'hc000_0000);
    check_op("neg inf times neg inf", 32'hff80_0000, 32'hff80_0000);
    check_op("zero times three", 32'h0000_0000, 32'h4040_0000);
    check_op("neg zero times three", 32'h8000_0000, 32'h4040_0000);
    check_op("subnormal times neg five", 32'h0000_0001, 32'hc0a0_0000);
    check_op("three times neg subnormal", 32'h4040_0000, 32'h807f_ffff);
  endtask

  task automatic range_limits();
    check_op("large times large", 32'h7f00_0000, 32'h7f00_0000);
    check_op("neg large times large", 32'hfe80_0000, 32'h7e80_0000);
    check_op("max rounds past max", 32'h7f7f_ffff, 32'h3f80_0001);
    check_op("tiny times tiny", 32'h0080_0000, 32'h0080_0000);
    check_op("neg tiny times half", 32'h8080_0000, 32'h3f00_0000);
  endtask

  // strobe held while busy gives one done and a held result
  task automatic busy_and_hold();
    logic [34:0] exp_r;
    logic [31:0] z_held;
    logic        prev_done;
    int          dones;
    exp_r     = model_mul(32'h4049_0fdb, 32'h3fb5_04f3);  // pi * sqrt2
    dones     = 0;
    prev_done = 1'b0;
    z_held    = '0;
    issue(32'h4049_0fdb, 32'h3fb5_04f3);
    in_valid <= 1'b1;                     // overrides the release with a strobe to ignore
    a_in     <= 32'h7fc0_0000;
    b_in     <= 32'h3f80_0000;
    @(negedge clk);
    assert (busy)
    else
    begin
      others++;
      $display("busy hold: busy did not rise after the accepted strobe");
    end
    repeat (2) @(posedge clk);
    in_valid <= 1'b0;
    repeat (10)
    begin
      @(negedge clk);
      if (prev_done)
        assert (!busy)
        else
        begin
          others++;
          $display("busy hold: busy still high in the cycle after done");
        end
      if (done)
      begin
        dones++;
        z_held = z;
      end
      else if (dones > 0)
        assert (z === z_held)
        else
        begin
          mismatches++;
          $display("MISMATCH busy hold z expected %h actual %h", z_held, z);
        end
      prev_done = done;
    end
    assert (dones == 1)
    else
    begin
      mismatches++;
      $display("MISMATCH busy hold done count expected 1 actual %0d", dones);
    end
    assert (z_held === exp_r[31:0])
    else
    begin
      mismatches++;
      $display("MISMATCH busy hold z expected %h actual %h", exp_r[31:0], z_held);
    end
  endtask

  task automatic reset_mid_op();
    issue(32'h3fc0_0000, 32'h4040_0000);
    @(posedge clk);                       // operation in the multiply stage
    mid_rst <= 1'b1;
    repeat (2) @(posedge clk);
    mid_rst <= 1'b0;
    repeat (6)
    begin
      @(negedge clk);
      assert (!done && !busy && (z === '0))
      else
      begin
        others++;
        $display("reset mid op: done, busy or z not cleared after reset");
      end
    end
    check_op("reset recovery", 32'h3fc0_0000, 32'h4040_0000);
  endtask

  initial
  begin
    in_valid   = 1'b0;
    a_in       = '0;
    b_in       = '0;
    mid_rst    = 1'b0;
    mismatches = 0;
    others     = 0;
    void'($urandom(32'hb20a01f3));
    @(negedge por_rst);
    exact_products();
    rounding_cases();
    special_operands();
    range_limits();
    busy_and_hold();
    reset_mid_op();
    @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, others, dut_i.chk_i.fail_count);
    if ((mismatches == 0) && (others == 0) && (dut_i.chk_i.fail_count == 0))
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // about 8 cycles per operation plus slack
  initial
  begin
    #(op_count * 8 * 20 + margin_ns);
    $display("watchdog: run did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: rtl/fmul_ctrl.sv
module fmul_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fmul_pkg::class_e class_a,
  input  fmul_pkg::class_e class_b,
  output logic             busy,
  output logic             load,
  output logic             mult_en,
  output logic             norm_en,
  output logic             round_en,
  output logic             special_en,
  output logic             done
);

  fmul_pkg::state_e state;
  fmul_pkg::state_e state_nxt;
  logic             special; // any operand not normal

  assign special = (class_a != fmul_pkg::normal) || (class_b != fmul_pkg::normal);

  always_comb
  begin
    state_nxt  = state;
    load       = 1'b0;
    mult_en    = 1'b0;
    norm_en    = 1'b0;
    round_en   = 1'b0;
    special_en = 1'b0;
    case (state)
      // result cycles also take a new strobe, back to back
      fmul_pkg::idle, fmul_pkg::round, fmul_pkg::done_s:
      begin
        load      = in_valid;
        state_nxt = in_valid ? fmul_pkg::unpack : fmul_pkg::idle;
      end
      fmul_pkg::unpack:
      begin
        if (special)
        begin
          special_en = 1'b1;             // result straight from the classes
          state_nxt  = fmul_pkg::done_s;
        end
        else
        begin
          mult_en   = 1'b1;
          state_nxt = fmul_pkg::multiply;
        end
      end
      fmul_pkg::multiply:
      begin
        norm_en   = 1'b1;
        state_nxt = fmul_pkg::normalize;
      end
      fmul_pkg::normalize:
      begin
        round_en  = 1'b1;
        state_nxt = fmul_pkg::round;
      end
      default: state_nxt = fmul_pkg::idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= fmul_pkg::idle;
      busy  <= 1'b0;
      done  <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      busy  <= state_nxt != fmul_pkg::idle;
      done  <= (state_nxt == fmul_pkg::round) || (state_nxt == fmul_pkg::done_s); // one cycle
    end
  end

endmodule

// File: rtl/fmul_mant_mult.sv
`include "fmul_params.svh"

module fmul_mant_mult (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           mult_en,
  input  fmul_pkg::operand_t             op_a,
  input  fmul_pkg::operand_t             op_b,
  output logic                           prod_sign,
  output logic signed [`FMUL_PEXP_W-1:0] prod_exp,
  output logic [`FMUL_PROD_W-1:0]        product
);

  logic signed [`FMUL_PEXP_W-1:0] exp_a; // sign extended
  logic signed [`FMUL_PEXP_W-1:0] exp_b;

  assign exp_a = `FMUL_PEXP_W'($signed(op_a.u.exp));
  assign exp_b = `FMUL_PEXP_W'($signed(op_b.u.exp));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prod_sign <= 1'b0;
      prod_exp  <= '0;
      product   <= '0;
    end
    else if (mult_en)
    begin
      prod_sign <= op_a.u.sign ^ op_b.u.sign;
      prod_exp  <= exp_a + exp_b;          // one bit of headroom
      product   <= op_a.u.mant * op_b.u.mant; // 1.x * 1.x lands in [1,4)
    end
  end

endmodule

// File: rtl/fmul_normalize.sv
`include "fmul_params.svh"

module fmul_normalize (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           norm_en,
  input  logic                           prod_sign,
  input  logic signed [`FMUL_PEXP_W-1:0] prod_exp,
  input  logic [`FMUL_PROD_W-1:0]        product,
  output fmul_pkg::norm_t                norm
);

  localparam int lo = `FMUL_PROD_W - `FMUL_MANT_W; // bits below a high mantissa

  logic                    top;    // product >= 2
  logic [`FMUL_MANT_W-1:0] mant_n;
  fmul_pkg::grs_t          grs_n;

  assign top = product[`FMUL_PROD_W-1];

  always_comb
  begin
    if (top)
    begin
      mant_n        = product[`FMUL_PROD_W-1 -: `FMUL_MANT_W];
      grs_n.guard   = product[lo-1];
      grs_n.rnd     = product[lo-2];
      grs_n.sticky  = |product[lo-3:0];
    end
    else
    begin
      mant_n        = product[`FMUL_PROD_W-2 -: `FMUL_MANT_W]; // one left shift
      grs_n.guard   = product[lo-2];
      grs_n.rnd     = product[lo-3];
      grs_n.sticky  = |product[lo-4:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      norm <= '0;
    else if (norm_en)
    begin
      norm.sign <= prod_sign;
      norm.exp  <= prod_exp + `FMUL_PEXP_W'(top); // bump when the 2's bit is set
      norm.mant <= mant_n;
      norm.grs  <= grs_n;
    end
  end

endmodule

// File: rtl/fmul_params.svh
`ifndef FMUL_PARAMS_SVH
`define FMUL_PARAMS_SVH

// ieee-754 single precision field widths
`define FMUL_EXP_W  8
`define FMUL_FRAC_W 23
`define FMUL_W      32
`define FMUL_BIAS   127
`define FMUL_QNAN   32'h7fc0_0000 // canonical quiet nan

// derived widths
`define FMUL_MANT_W (`FMUL_FRAC_W + 1) // hidden bit included
`define FMUL_UEXP_W (`FMUL_EXP_W + 2) // signed unbiased exponent
`define FMUL_PEXP_W (`FMUL_EXP_W + 3) // exponent sum, no wrap
`define FMUL_PROD_W (2 * `FMUL_MANT_W) // full mantissa product

`endif

// File: rtl/fmul_pkg.sv
package fmul_pkg;

  `include "fmul_params.svh"

  // control states, named after the data that is valid in that cycle
  typedef enum logic [2:0] {
    idle,
    unpack,
    multiply,
    normalize,
    round,  // rounded normal result on z
    done_s  // special result on z
  } state_e;

  // subnormal encodings land in zero
  typedef enum logic [1:0] {
    zero,
    normal,
    inf,
    nan
  } class_e;

  typedef struct packed {
    logic                           sign;
    logic signed [`FMUL_UEXP_W-1:0] exp;  // bias removed
    logic [`FMUL_MANT_W-1:0]        mant; // hidden bit on top
  } unpacked_t;

  typedef struct packed {
    unpacked_t u;
    class_e    cls;
  } operand_t;

  typedef struct packed {
    logic guard;
    logic rnd;    // round bit
    logic sticky;
  } grs_t;

  typedef struct packed {
    logic                           sign;
    logic signed [`FMUL_PEXP_W-1:0] exp;
    logic [`FMUL_MANT_W-1:0]        mant;
    grs_t                           grs;
  } norm_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
  } status_t;

endpackage

// File: rtl/fmul_round_pack.sv
`include "fmul_params.svh"

module fmul_round_pack (
  input  logic               clk,
  input  logic               rst,
  input  logic               round_en,
  input  logic               special_en,
  input  fmul_pkg::norm_t    norm,
  input  fmul_pkg::operand_t op_a,
  input  fmul_pkg::operand_t op_b,
  output logic [`FMUL_W-1:0] z,
  output fmul_pkg::status_t  status
);

  logic                           round_up;
  logic [`FMUL_MANT_W:0]          mant_r; // extra bit catches the carry
  logic signed [`FMUL_PEXP_W-1:0] exp_r;
  logic signed [`FMUL_PEXP_W-1:0] exp_biased;
  logic [`FMUL_FRAC_W-1:0]        frac_r;
  logic                           ovf;
  logic                           unf;
  logic                           sign_s; // sign for special results
  logic                           a_inf;
  logic                           b_inf;
  logic                           a_zero;
  logic                           b_zero;
  logic                           inval;

  // nearest even rounds up above half or on an exact half with odd lsb
  assign round_up   = norm.grs.guard & (norm.grs.rnd | norm.grs.sticky | norm.mant[0]);
  assign mant_r     = {1'b0, norm.mant} + {{`FMUL_MANT_W{1'b0}}, round_up};
  assign exp_r      = norm.exp + `FMUL_PEXP_W'(mant_r[`FMUL_MANT_W]);
  assign frac_r     = mant_r[`FMUL_FRAC_W-1:0]; // a rounding carry leaves it zero
  assign ovf        = exp_r > `FMUL_BIAS;        // above 127
  assign unf        = exp_r < (1 - `FMUL_BIAS);  // below -126 gets flushed
  assign exp_biased = exp_r + `FMUL_PEXP_W'(`FMUL_BIAS);

  assign sign_s = op_a.u.sign ^ op_b.u.sign;
  assign a_inf  = op_a.cls == fmul_pkg::inf;
  assign b_inf  = op_b.cls == fmul_pkg::inf;
  assign a_zero = op_a.cls == fmul_pkg::zero;
  assign b_zero = op_b.cls == fmul_pkg::zero;
  assign inval  = (op_a.cls == fmul_pkg::nan) | (op_b.cls == fmul_pkg::nan)
                | (a_inf & b_zero) | (b_inf & a_zero); // inf * 0 is invalid too

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      z      <= '0;
      status <= '0;
    end
    else if (special_en)
    begin
      status <= '0;
      if (inval)
      begin
        z              <= `FMUL_QNAN;
        status.invalid <= 1'b1;
      end
      else if (a_inf | b_inf)
        z <= {sign_s, {`FMUL_EXP_W{1'b1}}, {`FMUL_FRAC_W{1'b0}}};
      else
        z <= {sign_s, {(`FMUL_W-1){1'b0}}}; // signed zero
    end
    else if (round_en)
    begin
      status <= '0;
      if (ovf)
      begin
        z               <= {norm.sign, {`FMUL_EXP_W{1'b1}}, {`FMUL_FRAC_W{1'b0}}};
        status.overflow <= 1'b1;
      end
      else if (unf)
      begin
        z                <= {norm.sign, {(`FMUL_W-1){1'b0}}};
        status.underflow <= 1'b1;
      end
      else
        z <= {norm.sign, exp_biased[`FMUL_EXP_W-1:0], frac_r};
    end
  end

endmodule

// File: rtl/fmul_top.sv
`include "fmul_params.svh"

module fmul_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [`FMUL_W-1:0] a,
  input  logic [`FMUL_W-1:0] b,
  output logic [`FMUL_W-1:0] z,
  output fmul_pkg::status_t  status,
  output logic               done,
  output logic               busy
);

  logic                           load;
  logic                           mult_en;
  logic                           norm_en;
  logic                           round_en;
  logic                           special_en;
  fmul_pkg::operand_t             op_a;
  fmul_pkg::operand_t             op_b;
  logic                           prod_sign;
  logic signed [`FMUL_PEXP_W-1:0] prod_exp;
  logic [`FMUL_PROD_W-1:0]        product;
  fmul_pkg::norm_t                norm;

  fmul_ctrl ctrl_i (
    .clk, .rst, .in_valid,
    .class_a(op_a.cls), .class_b(op_b.cls), // path choice lives here only
    .busy, .load, .mult_en, .norm_en, .round_en, .special_en, .done
  );

  fmul_unpack unpack_i (.clk, .rst, .load, .a, .b, .op_a, .op_b);

  fmul_mant_mult mult_i (.clk, .rst, .mult_en, .op_a, .op_b, .prod_sign, .prod_exp, .product);

  fmul_normalize norm_i (.clk, .rst, .norm_en, .prod_sign, .prod_exp, .product, .norm);

  fmul_round_pack round_i (
    .clk, .rst, .round_en, .special_en,
    .norm, .op_a, .op_b, // operands feed the special results
    .z, .status
  );

endmodule

// File: rtl/fmul_unpack.sv
`include "fmul_params.svh"

module fmul_unpack (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic [`FMUL_W-1:0]   a,
  input  logic [`FMUL_W-1:0]   b,
  output fmul_pkg::operand_t   op_a,
  output fmul_pkg::operand_t   op_b
);

  // field split plus class decode for one word
  function automatic fmul_pkg::operand_t split(input logic [`FMUL_W-1:0] w);
    logic [`FMUL_EXP_W-1:0]  e;
    logic [`FMUL_FRAC_W-1:0] f;
    fmul_pkg::operand_t      o;
    e = w[`FMUL_W-2:`FMUL_FRAC_W];
    f = w[`FMUL_FRAC_W-1:0];
    o.u.sign = w[`FMUL_W-1];
    o.u.exp  = `FMUL_UEXP_W'(e) - `FMUL_UEXP_W'(`FMUL_BIAS); // unbias
    if (e == '0)
    begin
      o.cls = fmul_pkg::zero;     // true zero or subnormal
    end
    else if (e == '1)
    begin
      o.cls = (f != '0) ? fmul_pkg::nan : fmul_pkg::inf;
    end
    else
    begin
      o.cls = fmul_pkg::normal;
    end
    // hidden bit only for normals, zero mantissa otherwise
    o.u.mant = (o.cls == fmul_pkg::normal) ? {1'b1, f} : '0;
    return o;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      op_a.cls <= fmul_pkg::zero; // payload left as is
      op_b.cls <= fmul_pkg::zero;
    end
    else if (load)
    begin
      op_a <= split(a);
      op_b <= split(b);
    end
  end

endmodule
